//--- mul_vectors.txt
// columns: a b expected_product, all hex
// a and b are 24-bit operands, the product is 48 bits
000000 000000 000000000000
000001 000001 000000000001
000000 FFFFFF 000000000000
FFFFFF 000001 000000FFFFFF
000001 FFFFFF 000000FFFFFF
FFFFFF FFFFFF FFFFFE000001
800000 800000 400000000000
800000 000002 000001000000
000400 001000 000000400000
555555 000002 000000AAAAAA
AAAAAA FFFFFF AAAAA9555556
555555 FFFFFF 555554AAAAAB
FFFFFF 800000 7FFFFF800000
FFFFFF 000002 000001FFFFFE
C00000 C00000 900000000000
FFFFFF 800001 8000007FFFFF
000003 000005 00000000000F
123456 000010 000001234560
F0F0F0 000100 0000F0F0F000
0F0F0F FFFFFF 0F0F0EF0F0F1

//--- tb.f
mul_pkg.sv
partial_product_gen.sv
dadda_layer.sv
dadda_tree.sv
mantissa_mul.sv
tb_clock_gen.sv
tb_mantissa_mul.sv

//--- Makefile
TOP := tb_mantissa_mul

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir

//--- tb_mantissa_mul.sv
`timescale 1ns/10ps

// testbench for the pipelined dadda multiplier
module tb_mantissa_mul import mul_pkg::*; ();

  localparam int VEC_CNT = 20;
  localparam int RAND_CNT = 200;
  localparam int PULSE_CNT = 40;
  localparam int SWAP_CNT = 50;
  localparam int RESET_TIMEOUT = 50;
  localparam int DRAIN_TIMEOUT = 10;
  localparam int unsigned SEED = 32'heb38_f7ae;

  logic     clk;
  logic     arst_n;
  logic     in_valid;
  operand_t a;
  operand_t b;
  logic     out_valid;
  product_t product;

  // each vector is the three words a, b and expected product
  product_t vec_mem [3*VEC_CNT];
  // operands and products still in the pipe with the oldest first
  product_t exp_q [$];
  operand_t a_q [$];
  operand_t b_q [$];
  int checks = 0;
  int errors = 0;
  // in_valid seen at the last two falling edges
  logic [1:0] valid_hist = 2'b00;

  tb_clock_gen tb_clock_gen_i (
    .clk   (clk),
    .arst_n(arst_n)
  );

  mantissa_mul mantissa_mul_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .a        (a),
    .b        (b),
    .out_valid(out_valid),
    .product  (product)
  );

  // plain unsigned product that is 48 bits wide so nothing is lost
  function automatic product_t ref_product(input operand_t x, input operand_t y);
    return product_t'(x) * product_t'(y);
  endfunction

  // one operand pair for one cycle with the expected result queued alongside
  task automatic drive_pair(input operand_t x, input operand_t y, input product_t p);
    @(posedge clk);
    in_valid <= 1'b1;
    a <= x;
    b <= y;
    exp_q.push_back(p);
    a_q.push_back(x);
    b_q.push_back(y);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  // wait until every queued product has come out
  task automatic drain(input string name);
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() > 0) begin
      errors++;
      $display("timeout in test %s: %0d products never came out", name, exp_q.size());
      exp_q.delete();
      a_q.delete();
      b_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("test %s done, %0d errors", name, errors - errors_before);
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    product_t exp_p;
    operand_t exp_a;
    operand_t exp_b;
    // out_valid must follow in_valid by exactly two edges
    checks++;
    assert (out_valid === valid_hist[1]) else begin
      errors++;
      $display("MISMATCH t=%0t out_valid expected %b got %b", $time, valid_hist[1], out_valid);
    end
    if (out_valid === 1'b1) begin
      checks++;
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("out_valid high at t=%0t with no operands pending", $time);
      end
      if (exp_q.size() > 0) begin
        exp_p = exp_q.pop_front();
        exp_a = a_q.pop_front();
        exp_b = b_q.pop_front();
        checks++;
        assert (product === exp_p) else begin
          errors++;
          $display("MISMATCH t=%0t a=%h b=%h expected=%h actual=%h",
                   $time, exp_a, exp_b, exp_p, product);
        end
      end
    end
    valid_hist = {valid_hist[0], in_valid};
  end

  initial begin
    int errors_before;
    int waited;
    operand_t x;
    operand_t y;
    in_valid <= 1'b0;
    a <= '0;
    b <= '0;
    void'($urandom(SEED));

    // reset and then idle cycles with out_valid held low
    errors_before = errors;
    waited = 0;
    while (arst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (arst_n !== 1'b1) begin
      errors++;
      $display("timeout: reset was never released");
    end
    idle(6);
    report_test("reset", errors_before);

    // directed pairs from the vector file
    errors_before = errors;
    $readmemh("mul_vectors.txt", vec_mem);
    for (int i = 0; i < VEC_CNT; i++) begin
      drive_pair(operand_t'(vec_mem[3*i]), operand_t'(vec_mem[3*i+1]), vec_mem[3*i+2]);
    end
    idle(1);
    drain("directed");
    report_test("directed", errors_before);

    // back-to-back random pairs keep two in flight
    errors_before = errors;
    for (int i = 0; i < RAND_CNT; i++) begin
      x = operand_t'($urandom);
      y = operand_t'($urandom);
      drive_pair(x, y, ref_product(x, y));
    end
    idle(1);
    drain("random");
    report_test("random", errors_before);

    // single-cycle pulses with random gaps
    errors_before = errors;
    for (int i = 0; i < PULSE_CNT; i++) begin
      x = operand_t'($urandom);
      y = operand_t'($urandom);
      drive_pair(x, y, ref_product(x, y));
      idle(1 + int'($urandom % 4));
    end
    drain("latency");
    report_test("latency", errors_before);

    // same pair in both orders
    errors_before = errors;
    for (int i = 0; i < SWAP_CNT; i++) begin
      x = operand_t'($urandom);
      y = operand_t'($urandom);
      drive_pair(x, y, ref_product(x, y));
      drive_pair(y, x, ref_product(x, y));
    end
    idle(1);
    drain("commute");
    report_test("commute", errors_before);

    idle(2);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps

// free-running testbench clock and power-on reset
module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset held low for the first 4 rising edges
  initial begin
    arst_n <= 1'b0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

//--- mantissa_mul.sv
`timescale 1ns/10ps

// 24x24 unsigned dadda multiplier, two register stages
module mantissa_mul import mul_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     in_valid,
  input  operand_t a,
  input  operand_t b,
  output logic     out_valid,
  output product_t product
);

  // AND array
  heap_t pp_heap;
  // heap after layers 0 to SPLIT_LAYER, height 6
  heap_t mid_heap;
  heap_t stage_heap;
  logic  stage_valid;
  // at most two rows left here
  heap_t final_heap;
  logic [COLUMN_CNT-1:0] row0;
  logic [COLUMN_CNT-1:0] row1;
  product_t sum;

  partial_product_gen partial_product_gen_i (
    .a   (a),
    .b   (b),
    .heap(pp_heap)
  );

  // layers in front of the cut
  dadda_tree #(
    .FIRST_LAYER(0),
    .LAST_LAYER (SPLIT_LAYER)
  ) dadda_tree_head_i (
    .heap_in (pp_heap),
    .heap_out(mid_heap)
  );

  // stage register, loads every cycle, the valid bit travels alongside
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stage_heap  <= '0;
      stage_valid <= 1'b0;
    end else begin
      stage_heap  <= mid_heap;
      stage_valid <= in_valid;
    end
  end

  // remaining layers down to height 2
  dadda_tree #(
    .FIRST_LAYER(SPLIT_LAYER + 1),
    .LAST_LAYER (LAYER_CNT - 1)
  ) dadda_tree_tail_i (
    .heap_in (stage_heap),
    .heap_out(final_heap)
  );

  // pull the two rows out of the column heaps
  always_comb begin
    for (int c = 0; c < COLUMN_CNT; c++) begin
      row0[c] = final_heap[c][0];
      row1[c] = final_heap[c][1];
    end
  end

  // carry-propagate add, the carry out is product bit 47
  assign sum = PRODUCT_W'(row0) + PRODUCT_W'(row1);

  // output register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      product   <= '0;
      out_valid <= 1'b0;
    end else begin
      product   <= sum;
      out_valid <= stage_valid;
    end
  end

endmodule

//--- dadda_tree.sv
`timescale 1ns/10ps

// dadda layers FIRST_LAYER to LAST_LAYER, chained in order
module dadda_tree import mul_pkg::*; #(
  parameter int FIRST_LAYER = 0,
  parameter int LAST_LAYER  = SPLIT_LAYER
) (
  input  heap_t heap_in,
  output heap_t heap_out
);

  // link[k] is the heap entering layer k, the last one leaves the tree
  heap_t link [FIRST_LAYER:LAST_LAYER+1];

  assign link[FIRST_LAYER] = heap_in;

  for (genvar k = FIRST_LAYER; k <= LAST_LAYER; k++) begin : g_layer
    // each layer sees the packing the previous one left behind
    dadda_layer #(
      .LAYER(k)
    ) dadda_layer_i (
      .heap_in (link[k]),
      .heap_out(link[k+1])
    );
  end

  assign heap_out = link[LAST_LAYER+1];

endmodule

//--- dadda_layer.sv
`timescale 1ns/10ps

// one dadda layer, every column ends at or below DADDA_HEIGHT[LAYER]
module dadda_layer import mul_pkg::*; #(
  parameter int LAYER = 0
) (
  input  heap_t heap_in,
  output heap_t heap_out
);

  // counter outputs, sum[c][k] and carry[c][k] belong to counter k of column c
  heap_t sum;
  heap_t carry;

  for (genvar c = 0; c < COLUMN_CNT; c++) begin : g_col
    // heights before and after this layer
    localparam int H_IN  = column_height(LAYER, c);
    localparam int H_OUT = column_height(LAYER + 1, c);
    localparam int FA    = fa_count(LAYER, c);
    localparam int HA    = ha_count(LAYER, c);
    // counters sit on the lowest rows of the column
    localparam int USED  = 3 * FA + 2 * HA;
    localparam int NSUM  = FA + HA;
    // untouched bits above the counters
    localparam int NPASS = H_IN - USED;

    for (genvar k = 0; k < MAX_HEIGHT; k++) begin : g_ctr
      if (k < FA) begin : g_fa
        logic x;
        logic y;
        logic z;

        // full adder k takes rows 3k to 3k+2
        assign x = heap_in[c][3*k];
        assign y = heap_in[c][3*k+1];
        assign z = heap_in[c][3*k+2];
        assign sum[c][k]   = x ^ y ^ z;
        assign carry[c][k] = (x & y) | (z & (x ^ y));
      end else if (k < NSUM) begin : g_ha
        // the single half adder right above the full adders
        assign sum[c][k]   = heap_in[c][USED-2] ^ heap_in[c][USED-1];
        assign carry[c][k] = heap_in[c][USED-2] & heap_in[c][USED-1];
      end else begin : g_idle
        assign sum[c][k]   = 1'b0;
        assign carry[c][k] = 1'b0;
      end
    end

    // repack from row 0: sums, then pass bits, then carries from column c-1
    for (genvar r = 0; r < MAX_HEIGHT; r++) begin : g_row
      if (r < NSUM) begin : g_sum
        assign heap_out[c][r] = sum[c][r];
      end else if (r < NSUM + NPASS) begin : g_pass
        assign heap_out[c][r] = heap_in[c][USED + r - NSUM];
      end else if (r < H_OUT) begin : g_carry
        // column 0 never gets here, it has no carries in
        assign heap_out[c][r] = carry[c-1][r - NSUM - NPASS];
      end else begin : g_empty
        assign heap_out[c][r] = 1'b0;
      end
    end
  end

endmodule

//--- partial_product_gen.sv
`timescale 1ns/10ps

// AND array, every a[i] & b[j] lands in column i + j
module partial_product_gen import mul_pkg::*; (
  input  operand_t a,
  input  operand_t b,
  output heap_t    heap
);

  for (genvar c = 0; c < COLUMN_CNT; c++) begin : g_col
    // lowest index of a that still reaches column c
    localparam int A_LO = (c < OPERAND_W) ? 0 : c - OPERAND_W + 1;
    // number of (i, j) pairs summing to c
    localparam int HEIGHT = column_height(0, c);

    for (genvar r = 0; r < MAX_HEIGHT; r++) begin : g_row
      if (r < HEIGHT) begin : g_pp
        // row r takes a[A_LO + r], the b index follows from i + j = c
        assign heap[c][r] = a[A_LO + r] & b[c - A_LO - r];
      end else begin : g_empty
        // above the top of the column
        assign heap[c][r] = 1'b0;
      end
    end
  end

endmodule

//--- mul_pkg.sv
package mul_pkg;

  // operand and product widths
  localparam int OPERAND_W = 24;
  localparam int PRODUCT_W = 2 * OPERAND_W;
  // AND array spans columns 0 to 46, bit 47 comes only from the final adder
  localparam int COLUMN_CNT = PRODUCT_W - 1;
  // tallest column of the AND array, the middle one
  localparam int MAX_HEIGHT = OPERAND_W;

  // dadda schedule, layer k brings every column down to DADDA_HEIGHT[k]
  localparam int LAYER_CNT = 7;
  // last layer in front of the pipeline register
  localparam int SPLIT_LAYER = 3;
  localparam int DADDA_HEIGHT [LAYER_CNT] = '{19, 13, 9, 6, 4, 3, 2};

  typedef logic [OPERAND_W-1:0] operand_t;
  typedef logic [PRODUCT_W-1:0] product_t;
  // heap[c][r] is row r of column c, filled from row 0 up, empty rows are zero
  typedef logic [COLUMN_CNT-1:0][MAX_HEIGHT-1:0] heap_t;
  // per-column bit counts, elaboration only
  typedef logic [COLUMN_CNT-1:0][7:0] height_vec_t;

  // heights of all columns after the first `boundary` layers
  function automatic height_vec_t heights_after(int boundary);
    height_vec_t h;
    int cin;
    int e;
    for (int c = 0; c < COLUMN_CNT; c++) begin
      h[c] = 8'((c < OPERAND_W) ? c + 1 : PRODUCT_W - 1 - c);
    end
    for (int k = 0; k < boundary; k++) begin
      cin = 0;
      for (int c = 0; c < COLUMN_CNT; c++) begin
        // excess over the target, carries from below included
        e = int'(h[c]) + cin - DADDA_HEIGHT[k];
        if (e < 0) begin
          e = 0;
        end
        // each fa removes two bits, each ha one, so e bits go in total
        h[c] = 8'(int'(h[c]) + cin - e);
        // one carry per counter moves up
        cin = e / 2 + e % 2;
      end
    end
    return h;
  endfunction

  // valid bits in column col after `boundary` layers, 0 is the AND array
  function automatic int column_height(int boundary, int col);
    height_vec_t h;
    h = heights_after(boundary);
    return int'(h[col]);
  endfunction

  // bits that layer `layer` must remove from its own bits of column col
  function automatic int layer_excess(int layer, int col);
    height_vec_t h;
    int cin;
    int e;
    h = heights_after(layer);
    cin = 0;
    e = 0;
    // walk up from column 0 to find the carries arriving at col
    for (int c = 0; c <= col; c++) begin
      e = int'(h[c]) + cin - DADDA_HEIGHT[layer];
      if (e < 0) begin
        e = 0;
      end
      cin = e / 2 + e % 2;
    end
    return e;
  endfunction

  function automatic int fa_count(int layer, int col);
    return layer_excess(layer, col) / 2;
  endfunction

  // a ha only when a single excess bit is left over
  function automatic int ha_count(int layer, int col);
    return layer_excess(layer, col) % 2;
  endfunction

endpackage
